//--- design/pipe_trace_pkg.sv
package pipe_trace_pkg;

    // Datapath widths
    localparam int word_w      = 32;
    localparam int tag_w       = 8;
    localparam int stall_cnt_w = 4;
    localparam int cycle_w     = 16;

    // Instruction field widths
    localparam int op_w  = 6;
    localparam int reg_w = 5;

    // I-format opcodes, everything else decodes as R-format
    localparam logic [op_w-1:0] op_load  = 6'h23;
    localparam logic [op_w-1:0] op_store = 6'h2b;
    localparam logic [op_w-1:0] op_addi  = 6'h08;

    // One instruction word, two decodings
    typedef union packed {
        struct packed {
            logic [op_w-1:0]  opcode;
            logic [reg_w-1:0] rs1;
            logic [reg_w-1:0] rs2;
            logic [reg_w-1:0] rd;
            logic [10:0]      funct;
        } r_fmt;
        struct packed {
            logic [op_w-1:0]  opcode;
            logic [reg_w-1:0] rs1;
            logic [reg_w-1:0] rd;
            logic [15:0]      imm;
        } i_fmt;
    } instr_u;

    // True for the opcodes that use the immediate layout
    function automatic logic is_i_fmt(input logic [op_w-1:0] opcode);
        logic result;
        case (opcode)
            op_load,
            op_store,
            op_addi:  result = 1'b1;
            default:  result = 1'b0;
        endcase
        return result;
    endfunction

endpackage

//--- design/hazard_detect.sv
`timescale 1ns/1ps

module hazard_detect (
    input  logic                   id_valid,
    input  pipe_trace_pkg::instr_u id_word,
    input  logic                   ex_valid,
    input  pipe_trace_pkg::instr_u ex_word,
    output logic                   hazard
);

    logic                              ex_is_load;
    logic [pipe_trace_pkg::reg_w-1:0]  load_rd;
    logic                              id_is_r;
    logic                              rs1_match;
    logic                              rs2_match;

    // Execute side: a valid load that actually writes a register
    assign ex_is_load = ex_valid &&
                        (ex_word.i_fmt.opcode == pipe_trace_pkg::op_load);
    assign load_rd    = ex_word.i_fmt.rd;

    // Decode side format selects whether rs2 is a source
    assign id_is_r = !pipe_trace_pkg::is_i_fmt(id_word.r_fmt.opcode);

    // rs1 sits in the same bits in both layouts
    assign rs1_match = (id_word.r_fmt.rs1 == load_rd);

    // Bits [20:16] are a destination in I-format, so only R-format compares them
    assign rs2_match = id_is_r && (id_word.r_fmt.rs2 == load_rd);

    // Register 0 is never a real dependency
    assign hazard = id_valid && ex_is_load &&
                    (load_rd != '0) &&
                    (rs1_match || rs2_match);

endmodule

//--- design/stage_tracker.sv
`timescale 1ns/1ps

module stage_tracker (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   instr_valid,
    input  logic [pipe_trace_pkg::word_w-1:0]      instr_word,
    input  logic                                   stall,
    output logic                                   id_valid,
    output pipe_trace_pkg::instr_u                 id_word,
    output logic                                   ex_valid,
    output pipe_trace_pkg::instr_u                 ex_word,
    output logic                                   retire,
    output logic [pipe_trace_pkg::tag_w-1:0]       retire_tag,
    output logic [pipe_trace_pkg::word_w-1:0]      retire_word,
    output logic [pipe_trace_pkg::stall_cnt_w-1:0] retire_stalls
);

    // Stage indices
    localparam int n_stages = 5;
    localparam int s_if     = 0;
    localparam int s_id     = 1;
    localparam int s_ex     = 2;
    localparam int s_mem    = 3;
    localparam int s_wb     = 4;

    localparam logic [pipe_trace_pkg::stall_cnt_w-1:0] stall_max = '1;

    logic [n_stages-1:0]                    valid_q;
    logic [pipe_trace_pkg::tag_w-1:0]       tag_q    [n_stages];
    logic [pipe_trace_pkg::word_w-1:0]      word_q   [n_stages];
    // Fetch never accumulates stalls, so counts start at decode
    logic [pipe_trace_pkg::stall_cnt_w-1:0] stalls_q [s_id:s_wb];
    logic [pipe_trace_pkg::tag_w-1:0]       tag_cnt_q;
    logic                                   accept;

    assign accept = instr_valid && !stall;

    // Stage valids and the sequence tag counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q   <= '0;
            tag_cnt_q <= '0;
        end else begin
            // Fetch and decode hold in place during a stall
            if (!stall) begin
                valid_q[s_if] <= instr_valid;
                valid_q[s_id] <= valid_q[s_if];
            end

            // A held decode stage leaves a bubble behind it
            valid_q[s_ex]  <= valid_q[s_id] && !stall;
            valid_q[s_mem] <= valid_q[s_ex];
            valid_q[s_wb]  <= valid_q[s_mem];

            if (accept) begin
                tag_cnt_q <= tag_cnt_q + pipe_trace_pkg::tag_w'(1);
            end
        end
    end

    // Per-stage payload, qualified by the valids above
    always_ff @(posedge clk) begin
        if (!stall) begin
            word_q[s_if] <= instr_word;
            tag_q[s_if]  <= tag_cnt_q;

            word_q[s_id]   <= word_q[s_if];
            tag_q[s_id]    <= tag_q[s_if];
            stalls_q[s_id] <= '0;
        end else if (stalls_q[s_id] != stall_max) begin
            // Count decode hold cycles, pinned at the top value
            stalls_q[s_id] <= stalls_q[s_id] + pipe_trace_pkg::stall_cnt_w'(1);
        end

        // Execute onward always advances
        for (int s = s_ex; s < n_stages; s++) begin
            word_q[s]   <= word_q[s-1];
            tag_q[s]    <= tag_q[s-1];
            stalls_q[s] <= stalls_q[s-1];
        end
    end

    // Views for the hazard check
    assign id_valid = valid_q[s_id];
    assign id_word  = word_q[s_id];
    assign ex_valid = valid_q[s_ex];
    assign ex_word  = word_q[s_ex];

    // Leaving writeback is a retirement
    assign retire        = valid_q[s_wb];
    assign retire_tag    = tag_q[s_wb];
    assign retire_word   = word_q[s_wb];
    assign retire_stalls = stalls_q[s_wb];

endmodule

//--- design/retire_log.sv
`timescale 1ns/1ps

module retire_log #(
    parameter int log_depth = 8
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   retire,
    input  logic [pipe_trace_pkg::tag_w-1:0]       retire_tag,
    input  logic [pipe_trace_pkg::word_w-1:0]      retire_word,
    input  logic [pipe_trace_pkg::stall_cnt_w-1:0] retire_stalls,
    input  logic                                   rd_en,
    output logic [pipe_trace_pkg::tag_w-1:0]       log_tag,
    output logic [pipe_trace_pkg::word_w-1:0]      log_word,
    output logic [pipe_trace_pkg::stall_cnt_w-1:0] log_stalls,
    output logic [pipe_trace_pkg::cycle_w-1:0]     log_cycle,
    output logic                                   log_empty,
    output logic                                   log_overflow
);

    // Depth is a power of two, so pointers wrap on their own
    localparam int               ptr_w     = $clog2(log_depth);
    localparam logic [ptr_w:0]   depth_cnt = (ptr_w + 1)'(log_depth);

    logic [pipe_trace_pkg::tag_w-1:0]       tag_mem    [log_depth];
    logic [pipe_trace_pkg::word_w-1:0]      word_mem   [log_depth];
    logic [pipe_trace_pkg::stall_cnt_w-1:0] stalls_mem [log_depth];
    logic [pipe_trace_pkg::cycle_w-1:0]     cycle_mem  [log_depth];

    logic [pipe_trace_pkg::cycle_w-1:0] cycle_q;
    logic [ptr_w-1:0]                   wr_ptr_q;
    logic [ptr_w-1:0]                   rd_ptr_q;
    logic [ptr_w:0]                     count_q;
    logic                               full;
    logic                               push;
    logic                               pop;

    assign full      = (count_q == depth_cnt);
    assign log_empty = (count_q == '0);

    // Full log drops the record, empty log ignores reads
    assign push = retire && !full;
    assign pop  = rd_en && !log_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_q      <= '0;
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            log_overflow <= 1'b0;
        end else begin
            cycle_q <= cycle_q + pipe_trace_pkg::cycle_w'(1);

            if (push) begin
                wr_ptr_q <= wr_ptr_q + ptr_w'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + ptr_w'(1);
            end

            case ({push, pop})
                2'b10:   count_q <= count_q + (ptr_w + 1)'(1);
                2'b01:   count_q <= count_q - (ptr_w + 1)'(1);
                default: count_q <= count_q;
            endcase

            // Sticky until reset
            if (retire && full) begin
                log_overflow <= 1'b1;
            end
        end
    end

    // Record storage, stamped with the cycle of the write edge
    always_ff @(posedge clk) begin
        if (push) begin
            tag_mem[wr_ptr_q]    <= retire_tag;
            word_mem[wr_ptr_q]   <= retire_word;
            stalls_mem[wr_ptr_q] <= retire_stalls;
            cycle_mem[wr_ptr_q]  <= cycle_q;
        end
    end

    // Head record falls through
    assign log_tag    = tag_mem[rd_ptr_q];
    assign log_word   = word_mem[rd_ptr_q];
    assign log_stalls = stalls_mem[rd_ptr_q];
    assign log_cycle  = cycle_mem[rd_ptr_q];

endmodule

//--- design/pipe_trace_top.sv
`timescale 1ns/1ps

module pipe_trace_top #(
    parameter int log_depth = 8
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   instr_valid,
    input  logic [pipe_trace_pkg::word_w-1:0]      instr_word,
    input  logic                                   hold,
    input  logic                                   rd_en,
    output logic                                   stall,
    output logic [pipe_trace_pkg::tag_w-1:0]       log_tag,
    output logic [pipe_trace_pkg::word_w-1:0]      log_word,
    output logic [pipe_trace_pkg::stall_cnt_w-1:0] log_stalls,
    output logic [pipe_trace_pkg::cycle_w-1:0]     log_cycle,
    output logic                                   log_empty,
    output logic                                   log_overflow
);

    logic                                   id_valid;
    pipe_trace_pkg::instr_u                 id_word;
    logic                                   ex_valid;
    pipe_trace_pkg::instr_u                 ex_word;
    logic                                   hazard;
    logic                                   retire;
    logic [pipe_trace_pkg::tag_w-1:0]       retire_tag;
    logic [pipe_trace_pkg::word_w-1:0]      retire_word;
    logic [pipe_trace_pkg::stall_cnt_w-1:0] retire_stalls;

    // Either source freezes fetch and decode
    assign stall = hazard || hold;

    stage_tracker i_stage_tracker (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr_word    (instr_word),
        .stall         (stall),
        .id_valid      (id_valid),
        .id_word       (id_word),
        .ex_valid      (ex_valid),
        .ex_word       (ex_word),
        .retire        (retire),
        .retire_tag    (retire_tag),
        .retire_word   (retire_word),
        .retire_stalls (retire_stalls)
    );

    hazard_detect i_hazard_detect (
        .id_valid (id_valid),
        .id_word  (id_word),
        .ex_valid (ex_valid),
        .ex_word  (ex_word),
        .hazard   (hazard)
    );

    retire_log #(
        .log_depth (log_depth)
    ) i_retire_log (
        .clk           (clk),
        .rst           (rst),
        .retire        (retire),
        .retire_tag    (retire_tag),
        .retire_word   (retire_word),
        .retire_stalls (retire_stalls),
        .rd_en         (rd_en),
        .log_tag       (log_tag),
        .log_word      (log_word),
        .log_stalls    (log_stalls),
        .log_cycle     (log_cycle),
        .log_empty     (log_empty),
        .log_overflow  (log_overflow)
    );

endmodule

//--- bench/pipe_trace_asserts.sv
`timescale 1ns/1ps

module pipe_trace_asserts (
    input logic                              clk,
    input logic                              rst,
    input logic                              hold,
    input logic                              ex_valid,
    input logic [pipe_trace_pkg::word_w-1:0] id_word,
    input logic                              retire,
    input logic [pipe_trace_pkg::tag_w-1:0]  retire_tag,
    input logic                              log_overflow
);

    // Back-to-back retirements are distinct records in tag order
    retire_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        retire |=> !retire || (retire_tag == $past(retire_tag) + pipe_trace_pkg::tag_w'(1))
    ) else $error("retire held the same record for two cycles");

    // Overflow is sticky until reset
    overflow_sticky: assert property (
        @(posedge clk) disable iff (rst)
        !$fell(log_overflow)
    ) else $error("log_overflow fell without reset");

    // External hold freezes decode and leaves a bubble in execute
    hold_freezes_decode: assert property (
        @(posedge clk) disable iff (rst)
        hold |=> !ex_valid && $stable(id_word)
    ) else $error("hold high but decode moved on");

endmodule

bind pipe_trace_top pipe_trace_asserts i_pipe_trace_asserts (
    .clk          (clk),
    .rst          (rst),
    .hold         (hold),
    .ex_valid     (ex_valid),
    .id_word      (id_word),
    .retire       (retire),
    .retire_tag   (retire_tag),
    .log_overflow (log_overflow)
);

//--- bench/pipe_trace_tb.sv
`timescale 1ns/1ps

module pipe_trace_tb;

    localparam int depth = 8;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr_word;
    logic        hold;
    logic        rd_en;
    logic        stall;
    logic [7:0]  log_tag;
    logic [31:0] log_word;
    logic [3:0]  log_stalls;
    logic [15:0] log_cycle;
    logic        log_empty;
    logic        log_overflow;

    int          err_cnt;
    int          timeout_cnt;
    logic [31:0] lcg_state;
    string       cur_test;

    // Reference pipeline state
    bit          m_valid [5];
    logic [31:0] m_word  [5];
    logic [7:0]  m_tag   [5];
    int          m_cnt   [5];
    logic [7:0]  m_tag_cnt;
    logic [15:0] m_cycle;
    bit          m_overflow;
    bit          m_stall;
    bit          m_full;
    bit          last_accept;
    logic [15:0] last_accept_cycle;

    // Expected log contents with the oldest record at the front
    logic [7:0]  exp_tag    [$];
    logic [31:0] exp_word   [$];
    int          exp_stalls [$];
    logic [15:0] exp_cycle  [$];

    pipe_trace_top #(
        .log_depth (depth)
    ) i_pipe_trace_top (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_word   (instr_word),
        .hold         (hold),
        .rd_en        (rd_en),
        .stall        (stall),
        .log_tag      (log_tag),
        .log_word     (log_word),
        .log_stalls   (log_stalls),
        .log_cycle    (log_cycle),
        .log_empty    (log_empty),
        .log_overflow (log_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Load-use rule for a valid load in EX whose nonzero rd is read by the decode word
    function automatic bit load_use(input bit idv, input logic [31:0] idw,
                                    input bit exv, input logic [31:0] exw);
        bit id_i;
        id_i = (idw[31:26] == pipe_trace_pkg::op_load) ||
               (idw[31:26] == pipe_trace_pkg::op_store) ||
               (idw[31:26] == pipe_trace_pkg::op_addi);
        if (!idv || !exv || exw[31:26] != pipe_trace_pkg::op_load || exw[20:16] == 5'd0) begin
            return 1'b0;
        end
        return (idw[25:21] == exw[20:16]) || (!id_i && idw[20:16] == exw[20:16]);
    endfunction

    function automatic bit pipe_busy();
        return m_valid[0] || m_valid[1] || m_valid[2] || m_valid[3] || m_valid[4];
    endfunction

    task automatic check_eq(input string name, input string field,
                            input int expected, input int actual);
        assert (expected == actual) else begin
            err_cnt++;
            $display("mismatch %s %s: expected %0h, actual %0h", name, field, expected, actual);
        end
    endtask

    // Reference model that checks the DUT at each edge and then advances
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < 5; s++) begin
                m_valid[s] = 1'b0;
                m_cnt[s]   = 0;
            end
            m_tag_cnt   = '0;
            m_cycle     = '0;
            m_overflow  = 1'b0;
            last_accept = 1'b0;
            exp_tag.delete();
            exp_word.delete();
            exp_stalls.delete();
            exp_cycle.delete();
        end else begin
            m_stall = hold || load_use(m_valid[1], m_word[1], m_valid[2], m_word[2]);
            check_eq(cur_test, "stall", m_stall, stall);
            check_eq(cur_test, "log_empty", exp_tag.size() == 0, log_empty);
            check_eq(cur_test, "log_overflow", m_overflow, log_overflow);

            m_full = (exp_tag.size() == depth);
            if (rd_en && exp_tag.size() != 0) begin
                void'(exp_tag.pop_front());
                void'(exp_word.pop_front());
                void'(exp_stalls.pop_front());
                void'(exp_cycle.pop_front());
            end
            if (m_valid[4]) begin
                if (m_full) begin
                    m_overflow = 1'b1;
                end else begin
                    exp_tag.push_back(m_tag[4]);
                    exp_word.push_back(m_word[4]);
                    exp_stalls.push_back(m_cnt[4]);
                    exp_cycle.push_back(m_cycle);
                end
            end

            for (int s = 4; s >= 2; s--) begin
                m_valid[s] = m_valid[s-1];
                m_word[s]  = m_word[s-1];
                m_tag[s]   = m_tag[s-1];
                m_cnt[s]   = m_cnt[s-1];
            end
            // Held decode sends a bubble into execute
            if (m_stall) begin
                m_valid[2]  = 1'b0;
                last_accept = 1'b0;
                if (m_cnt[1] < 15) begin
                    m_cnt[1]++;
                end
            end else begin
                m_valid[1]  = m_valid[0];
                m_word[1]   = m_word[0];
                m_tag[1]    = m_tag[0];
                m_cnt[1]    = 0;
                m_valid[0]  = instr_valid;
                m_word[0]   = instr_word;
                m_tag[0]    = m_tag_cnt;
                last_accept = instr_valid;
                if (instr_valid) begin
                    last_accept_cycle = m_cycle;
                    m_tag_cnt++;
                end
            end
            m_cycle++;
        end
    end

    task automatic reset_dut();
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr_word  = '0;
        hold        = 1'b0;
        rd_en       = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic send_instr(input logic [31:0] w, output logic [15:0] acc_cycle);
        int waited;
        waited      = 0;
        instr_valid = 1'b1;
        instr_word  = w;
        @(negedge clk);
        while (!last_accept && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!last_accept) begin
            timeout_cnt++;
            $display("timeout: instruction %h was never accepted", w);
        end
        acc_cycle   = last_accept_cycle;
        instr_valid = 1'b0;
    endtask

    task automatic read_one(input string name, output logic [7:0] tag,
                            output logic [3:0] stalls, output logic [15:0] cyc);
        int waited;
        waited = 0;
        while (log_empty && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (log_empty) begin
            timeout_cnt++;
            $display("timeout: %s waited for a record that never arrived", name);
            return;
        end
        assert (exp_tag.size() != 0) else begin
            err_cnt++;
            $display("%s: log holds a record the model does not expect", name);
        end
        if (exp_tag.size() != 0) begin
            check_eq(name, "tag", exp_tag[0], log_tag);
            check_eq(name, "word", exp_word[0], log_word);
            check_eq(name, "stalls", exp_stalls[0], log_stalls);
            check_eq(name, "cycle", exp_cycle[0], log_cycle);
        end
        tag    = log_tag;
        stalls = log_stalls;
        cyc    = log_cycle;
        rd_en  = 1'b1;
        @(negedge clk);
        rd_en = 1'b0;
    endtask

    task automatic wait_pipe_empty(input string name);
        int waited;
        waited = 0;
        while (pipe_busy() && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (pipe_busy()) begin
            timeout_cnt++;
            $display("timeout: %s pipeline never drained", name);
        end
        @(negedge clk);
    endtask

    function automatic logic [31:0] make_r(input int rs1, input int rs2, input int rd);
        pipe_trace_pkg::instr_u u;
        u = '0;
        u.r_fmt.rs1 = rs1[4:0];
        u.r_fmt.rs2 = rs2[4:0];
        u.r_fmt.rd  = rd[4:0];
        return u;
    endfunction

    function automatic logic [31:0] make_i(input logic [5:0] op, input int rs1,
                                           input int rd, input logic [15:0] imm);
        pipe_trace_pkg::instr_u u;
        u.i_fmt.opcode = op;
        u.i_fmt.rs1    = rs1[4:0];
        u.i_fmt.rd     = rd[4:0];
        u.i_fmt.imm    = imm;
        return u;
    endfunction

    task automatic back_to_back_retire();
        logic [15:0] acc0;
        logic [15:0] acc;
        logic [7:0]  tag;
        logic [3:0]  stalls;
        logic [15:0] cyc;
        cur_test = "back_to_back";
        send_instr(make_r(1, 2, 3), acc0);
        for (int i = 1; i < 5; i++) begin
            send_instr(make_r(i + 4, i + 10, i + 20), acc);
        end
        wait_pipe_empty("back_to_back");
        for (int i = 0; i < 5; i++) begin
            read_one("back_to_back", tag, stalls, cyc);
            check_eq("back_to_back", "tag", i, tag);
            check_eq("back_to_back", "stalls", 0, stalls);
            if (i == 0) begin
                check_eq("back_to_back", "cycle", 16'(acc0 + 16'd5), cyc);
            end
        end
    endtask

    task automatic load_use_stall(input int rd);
        logic [15:0] acc;
        logic [7:0]  tag;
        logic [3:0]  stalls;
        logic [15:0] cyc;
        int          delay;
        cur_test = "load_use";
        delay = (rd != 0) ? 1 : 0;
        send_instr(make_i(pipe_trace_pkg::op_load, 1, rd, 16'h0040), acc);
        send_instr(make_r(rd, 7, 9), acc);
        wait_pipe_empty("load_use");
        read_one("load_use", tag, stalls, cyc);
        read_one("load_use", tag, stalls, cyc);
        check_eq("load_use", "stalls", delay, stalls);
        check_eq("load_use", "cycle", 16'(acc + 16'd5 + 16'(delay)), cyc);
    endtask

    task automatic hold_stall_count(input int k);
        logic [15:0] acc;
        logic [7:0]  tag;
        logic [3:0]  stalls;
        logic [15:0] cyc;
        cur_test = "hold";
        send_instr(make_r(3, 4, 5), acc);
        @(negedge clk);
        hold = 1'b1;
        repeat (k) @(negedge clk);
        hold = 1'b0;
        wait_pipe_empty("hold");
        read_one("hold", tag, stalls, cyc);
        check_eq("hold", "stalls", (k > 15) ? 15 : k, stalls);
    endtask

    task automatic overflow_keeps_first();
        logic [15:0] acc;
        logic [7:0]  tag;
        logic [3:0]  stalls;
        logic [15:0] cyc;
        cur_test = "overflow";
        reset_dut();
        for (int i = 0; i < depth + 3; i++) begin
            send_instr(make_r(i + 1, 0, 2), acc);
        end
        wait_pipe_empty("overflow");
        check_eq("overflow", "log_overflow", 1, log_overflow);
        for (int i = 0; i < depth; i++) begin
            read_one("overflow", tag, stalls, cyc);
            check_eq("overflow", "tag", i, tag);
        end
        check_eq("overflow", "log_empty", 1, log_empty);
    endtask

    task automatic random_stream();
        logic [31:0] r;
        logic [31:0] w;
        logic [15:0] acc;
        logic [7:0]  tag;
        logic [3:0]  stalls;
        logic [15:0] cyc;
        int          drained;
        cur_test = "random";
        reset_dut();
        for (int i = 0; i < 300; i++) begin
            r = lcg_next();
            if (r[19:16] == 4'd0) begin
                hold = 1'b1;
                repeat (1 + r[22:20]) @(negedge clk);
                hold = 1'b0;
            end
            case (r[25:24])
                2'd0:    w = make_i(pipe_trace_pkg::op_load, r[27:26], r[29:28], r[15:0]);
                2'd1:    w = make_i(pipe_trace_pkg::op_store, r[27:26], r[29:28], r[15:0]);
                2'd2:    w = make_i(pipe_trace_pkg::op_addi, r[27:26], r[29:28], r[15:0]);
                default: w = make_r(r[27:26], r[29:28], r[31:30]);
            endcase
            send_instr(w, acc);
            if (!log_empty && r[9:8] != 2'd0) begin
                read_one("random", tag, stalls, cyc);
            end
        end
        wait_pipe_empty("random");
        drained = 0;
        while (!log_empty && drained <= depth) begin
            read_one("random", tag, stalls, cyc);
            drained++;
        end
        if (!log_empty) begin
            timeout_cnt++;
            $display("timeout: random log never drained");
        end
    endtask

    initial begin
        err_cnt     = 0;
        timeout_cnt = 0;
        lcg_state   = 32'd67054;
        cur_test    = "reset";
        reset_dut();
        back_to_back_retire();
        load_use_stall(5);
        load_use_stall(0);
        hold_stall_count(3);
        hold_stall_count(20);
        overflow_keeps_first();
        random_stream();
        $display("errors: %0d check failures, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- pipe_trace_top.f
design/pipe_trace_pkg.sv
design/hazard_detect.sv
design/stage_tracker.sv
design/retire_log.sv
design/pipe_trace_top.sv
bench/pipe_trace_asserts.sv
bench/pipe_trace_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module pipe_trace_tb \
    -f pipe_trace_top.f \
    -o pipe_trace_sim

./obj_dir/pipe_trace_sim | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    exit 0
else
    exit 1
fi
